// File: cache_cfg_pkg.sv
package cache_cfg_pkg;

    // Byte address layout is {tag, set, word, byte offset}.
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [22:0] tag_t;
    typedef logic [3:0]  set_t;
    typedef logic [2:0]  word_sel_t;

    // Tag and set together name one line.
    typedef logic [26:0] line_addr_t;

    typedef enum logic [1:0] {
        ic_idle,
        ic_rwait,
        ic_rbusy,
        ic_read
    } icache_state_t;

    typedef enum logic [2:0] {
        dc_idle,
        dc_rwait,
        dc_rbusy,
        dc_read,
        dc_write
    } dcache_state_t;

endpackage

// File: l2_bus_pkg.sv
package l2_bus_pkg;

    typedef logic [4:0] burst_len_t;

    // Strobes are single-cycle pulses.
    typedef struct packed {
        logic                 rreq;
        logic                 wreq;
        cache_cfg_pkg::addr_t addr;
        cache_cfg_pkg::word_t wdata;
        burst_len_t           burst_size;
    } l2_req_t;

    // Read data is valid from the first cycle busy is low.
    typedef struct packed {
        cache_cfg_pkg::word_t rdata;
        logic                 busy;
    } l2_rsp_t;

endpackage

// File: icache.sv
module icache (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       fetch_rreq,
    input  cache_cfg_pkg::addr_t       fetch_addr,
    output cache_cfg_pkg::word_t       fetch_rdata,
    output logic                       fetch_miss,
    output l2_bus_pkg::l2_req_t        l2_req,
    input  l2_bus_pkg::l2_rsp_t        l2_rsp,
    output cache_cfg_pkg::addr_t       peek_addr,
    input  cache_cfg_pkg::word_t       peek_rdata,
    input  logic                       peek_miss,
    input  cache_cfg_pkg::line_addr_t  invalidate_line,
    input  logic                       invalidate_req
);
    import cache_cfg_pkg::*;
    import l2_bus_pkg::*;

    icache_state_t state;
    l2_req_t       req_q;
    tag_t          tag_q [16];
    logic [15:0]   valid;
    word_t         data_q [128];
    tag_t          tag;
    tag_t          inv_tag;
    set_t          set;
    set_t          inv_set;
    set_t          fill_set;
    word_sel_t     word;
    word_sel_t     fill_cnt;
    logic          hit;
    logic          inv_hit;
    logic          start_fill;
    logic          fill_we;
    logic          fill_done;
    logic          fill_kill;

    assign {tag, set, word} = fetch_addr[31:2];
    assign {inv_tag, inv_set} = invalidate_line;

    assign hit = valid[set] && (tag_q[set] == tag);
    assign inv_hit = invalidate_req && (tag_q[inv_set] == inv_tag);

    // The data cache copy is newer when it exists.
    assign peek_addr = fetch_addr;
    assign fetch_rdata = peek_miss ? data_q[{set, word}] : peek_rdata;
    assign fetch_miss = fetch_rreq && ((peek_miss && !hit) || (state != ic_idle));

    assign start_fill = (state == ic_idle) && fetch_rreq && peek_miss && !hit;
    assign fill_we = ((state == ic_rbusy) && !l2_rsp.busy) || (state == ic_read);
    assign fill_done = (state == ic_read) && (fill_cnt == word_sel_t'(7));
    assign l2_req = req_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ic_idle;
            req_q <= '0;
            fill_kill <= 1'b0;
        end else begin
            case (state)
                ic_idle: begin
                    if (start_fill) begin
                        state <= ic_rwait;
                        req_q.rreq <= 1'b1;
                        req_q.addr <= {tag, set, 5'b0};
                        req_q.burst_size <= burst_len_t'(8);
                        fill_kill <= 1'b0;
                    end
                end
                ic_rwait: begin
                    req_q.rreq <= 1'b0;
                    state <= ic_rbusy;
                end
                ic_rbusy: begin
                    if (!l2_rsp.busy) begin
                        state <= ic_read;
                    end
                end
                ic_read: begin
                    if (fill_done) begin
                        state <= ic_idle;
                    end
                end
            endcase
            // A store to the line being filled makes the new copy stale.
            if (state != ic_idle && inv_hit && inv_set == fill_set) begin
                fill_kill <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else begin
            if (start_fill) begin
                valid[set] <= 1'b0;
            end
            if (fill_done && !fill_kill) begin
                valid[fill_set] <= 1'b1;
            end
            // Invalidation wins over a set in the same cycle.
            if (inv_hit) begin
                valid[inv_set] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_fill) begin
            tag_q[set] <= tag;
            fill_set <= set;
            fill_cnt <= '0;
        end else if (fill_we) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
        if (fill_we) begin
            data_q[{fill_set, fill_cnt}] <= l2_rsp.rdata;
        end
    end

    a_rreq_pulse: assert property (@(posedge clk) disable iff (reset)
        l2_req.rreq |=> !l2_req.rreq);

    a_idle_needs_miss: assert property (@(posedge clk) disable iff (reset)
        (state == ic_idle && !fetch_miss) |=> state == ic_idle);

endmodule

// File: dcache.sv
module dcache (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       data_rreq,
    input  logic                       data_wreq,
    input  cache_cfg_pkg::addr_t       data_addr,
    input  cache_cfg_pkg::word_t       data_wdata,
    output cache_cfg_pkg::word_t       data_rdata,
    output logic                       data_miss,
    output l2_bus_pkg::l2_req_t        l2_req,
    input  l2_bus_pkg::l2_rsp_t        l2_rsp,
    input  cache_cfg_pkg::addr_t       peek_addr,
    output cache_cfg_pkg::word_t       peek_rdata,
    output logic                       peek_miss,
    output cache_cfg_pkg::line_addr_t  invalidate_line,
    output logic                       invalidate_req
);
    import cache_cfg_pkg::*;
    import l2_bus_pkg::*;

    dcache_state_t state;
    l2_req_t       req_q;
    tag_t          tag_q [16];
    logic [15:0]   valid;
    word_t         data_q [128];
    tag_t          tag;
    tag_t          peek_tag;
    set_t          set;
    set_t          peek_set;
    set_t          fill_set;
    word_sel_t     word;
    word_sel_t     peek_word;
    word_sel_t     fill_cnt;
    logic          hit;
    logic          start_load;
    logic          start_store;
    logic          fill_we;
    logic          fill_done;
    logic          write_done;

    assign {tag, set, word} = data_addr[31:2];
    assign {peek_tag, peek_set, peek_word} = peek_addr[31:2];

    assign hit = valid[set] && (tag_q[set] == tag);
    assign start_load = (state == dc_idle) && data_rreq && !hit;
    assign start_store = (state == dc_idle) && data_wreq && !data_rreq;

    // Busy is sampled only after the request pulse has gone out.
    assign write_done = (state == dc_write) && !req_q.wreq && !l2_rsp.busy;
    assign fill_we = ((state == dc_rbusy) && !l2_rsp.busy) || (state == dc_read);
    assign fill_done = (state == dc_read) && (fill_cnt == word_sel_t'(7));

    assign data_rdata = data_q[{set, word}];
    assign data_miss = (data_rreq && (!hit || state != dc_idle))
                     || (data_wreq && !write_done);

    // Second lookup for the instruction cache.
    assign peek_rdata = data_q[{peek_set, peek_word}];
    assign peek_miss = !(valid[peek_set] && (tag_q[peek_set] == peek_tag));

    assign invalidate_line = {tag, set};
    assign invalidate_req = start_store;
    assign l2_req = req_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dc_idle;
            req_q <= '0;
        end else begin
            case (state)
                dc_idle: begin
                    if (start_load) begin
                        state <= dc_rwait;
                        req_q.rreq <= 1'b1;
                        req_q.addr <= {tag, set, 5'b0};
                        req_q.burst_size <= burst_len_t'(8);
                    end else if (start_store) begin
                        state <= dc_write;
                        req_q.wreq <= 1'b1;
                        req_q.addr <= data_addr;
                        req_q.wdata <= data_wdata;
                        req_q.burst_size <= burst_len_t'(1);
                    end
                end
                dc_rwait: begin
                    req_q.rreq <= 1'b0;
                    state <= dc_rbusy;
                end
                dc_rbusy: begin
                    if (!l2_rsp.busy) begin
                        state <= dc_read;
                    end
                end
                dc_read: begin
                    if (fill_done) begin
                        state <= dc_idle;
                    end
                end
                dc_write: begin
                    req_q.wreq <= 1'b0;
                    if (write_done) begin
                        state <= dc_idle;
                    end
                end
                default: state <= dc_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (start_load) begin
            valid[set] <= 1'b0;
        end else if (fill_done) begin
            valid[fill_set] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start_load) begin
            tag_q[set] <= tag;
            fill_set <= set;
            fill_cnt <= '0;
        end else if (fill_we) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
        // Store hits update the line at once. A store miss does not allocate.
        if (fill_we) begin
            data_q[{fill_set, fill_cnt}] <= l2_rsp.rdata;
        end else if (start_store && hit) begin
            data_q[{set, word}] <= data_wdata;
        end
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (reset)
        !(l2_req.rreq && l2_req.wreq));

endmodule

// File: l2_arbiter.sv
module l2_arbiter (
    input  logic                 clk,
    input  logic                 reset,
    input  l2_bus_pkg::l2_req_t  ic_req,
    output l2_bus_pkg::l2_rsp_t  ic_rsp,
    input  l2_bus_pkg::l2_req_t  dc_req,
    output l2_bus_pkg::l2_rsp_t  dc_rsp,
    output l2_bus_pkg::l2_req_t  mem_req,
    input  l2_bus_pkg::l2_rsp_t  mem_rsp
);
    import l2_bus_pkg::*;

    l2_req_t    ic_pend;
    l2_req_t    dc_pend;
    l2_req_t    ic_cand;
    l2_req_t    dc_cand;
    logic       ic_pend_v;
    logic       dc_pend_v;
    logic       ic_live;
    logic       dc_live;
    logic       ic_want;
    logic       dc_want;
    logic       grant;
    logic       grant_dc;
    logic       active;
    logic       owner_dc;
    logic       last_dc;
    logic       seen_busy;
    logic       in_data;
    logic       done;
    logic       is_write;
    burst_len_t beat;
    burst_len_t beats;

    assign ic_live = ic_req.rreq || ic_req.wreq;
    assign dc_live = dc_req.rreq || dc_req.wreq;
    assign ic_want = ic_pend_v || ic_live;
    assign dc_want = dc_pend_v || dc_live;
    assign ic_cand = ic_pend_v ? ic_pend : ic_req;
    assign dc_cand = dc_pend_v ? dc_pend : dc_req;

    // On a tie the client not served last time wins.
    assign grant = !active && (ic_want || dc_want);
    assign grant_dc = dc_want && (!ic_want || !last_dc);

    always_comb begin
        mem_req = '0;
        if (grant) begin
            mem_req = grant_dc ? dc_cand : ic_cand;
        end
    end

    assign in_data = active && seen_busy && !mem_rsp.busy;
    assign done = in_data && (is_write || beat == beats - 1'b1);

    assign ic_rsp.busy = ic_pend_v || (active && !owner_dc && !in_data);
    assign dc_rsp.busy = dc_pend_v || (active && owner_dc && !in_data);
    assign ic_rsp.rdata = owner_dc ? '0 : mem_rsp.rdata;
    assign dc_rsp.rdata = owner_dc ? mem_rsp.rdata : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            owner_dc <= 1'b0;
            last_dc <= 1'b0;
            seen_busy <= 1'b0;
            beat <= '0;
            ic_pend_v <= 1'b0;
            dc_pend_v <= 1'b0;
        end else begin
            if (grant) begin
                active <= 1'b1;
                owner_dc <= grant_dc;
                last_dc <= grant_dc;
                seen_busy <= 1'b0;
                beat <= '0;
            end else if (active) begin
                seen_busy <= seen_busy || mem_rsp.busy;
                if (in_data) begin
                    beat <= beat + 1'b1;
                end
                if (done) begin
                    active <= 1'b0;
                end
            end
            // A request that lost the bus waits here for replay.
            ic_pend_v <= ic_want && !(grant && !grant_dc);
            dc_pend_v <= dc_want && !(grant && grant_dc);
        end
    end

    always_ff @(posedge clk) begin
        if (ic_live) begin
            ic_pend <= ic_req;
        end
        if (dc_live) begin
            dc_pend <= dc_req;
        end
        if (grant) begin
            is_write <= mem_req.wreq;
            beats <= mem_req.burst_size;
        end
    end

    a_mem_one_strobe: assert property (@(posedge clk) disable iff (reset)
        !(mem_req.rreq && mem_req.wreq));

endmodule

// File: l2_memory.sv
module l2_memory #(
    parameter int L2_LATENCY = 4,
    parameter int MEM_WORDS  = 1024
) (
    input  logic                 clk,
    input  logic                 reset,
    input  l2_bus_pkg::l2_req_t  req,
    output l2_bus_pkg::l2_rsp_t  rsp
);
    import cache_cfg_pkg::*;
    import l2_bus_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int LAT_W = $clog2(L2_LATENCY + 1);

    word_t            mem [MEM_WORDS];
    word_t            wdata_q;
    logic [IDX_W-1:0] idx;
    logic [LAT_W-1:0] lat_cnt;
    burst_len_t       left;
    logic             busy;
    logic             streaming;
    logic             is_write;
    logic             accept;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = word_t'(i * 4) ^ 32'hA5A5_0000;
        end
    end

    assign accept = !busy && !streaming && (req.rreq || req.wreq);
    assign rsp.busy = busy;
    assign rsp.rdata = mem[idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            streaming <= 1'b0;
        end else if (busy) begin
            if (lat_cnt == '0) begin
                busy <= 1'b0;
                streaming <= !is_write;
            end
        end else if (streaming) begin
            if (left == burst_len_t'(1)) begin
                streaming <= 1'b0;
            end
        end else if (accept) begin
            busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            idx <= req.addr[IDX_W+1:2];
            is_write <= req.wreq;
            wdata_q <= req.wdata;
            left <= req.burst_size;
            lat_cnt <= LAT_W'(L2_LATENCY - 1);
        end else if (busy) begin
            lat_cnt <= lat_cnt - 1'b1;
            // Write lands on the edge where busy drops.
            if (lat_cnt == '0 && is_write) begin
                mem[idx] <= wdata_q;
            end
        end else if (streaming) begin
            idx <= idx + 1'b1;
            left <= left - 1'b1;
        end
    end

endmodule

// File: mem_subsystem.sv
module mem_subsystem #(
    parameter int L2_LATENCY = 4,
    parameter int MEM_WORDS  = 1024
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fetch_rreq,
    input  cache_cfg_pkg::addr_t  fetch_addr,
    output cache_cfg_pkg::word_t  fetch_rdata,
    output logic                  fetch_miss,
    input  logic                  data_rreq,
    input  logic                  data_wreq,
    input  cache_cfg_pkg::addr_t  data_addr,
    input  cache_cfg_pkg::word_t  data_wdata,
    output cache_cfg_pkg::word_t  data_rdata,
    output logic                  data_miss
);
    import cache_cfg_pkg::*;
    import l2_bus_pkg::*;

    l2_req_t    ic_req;
    l2_req_t    dc_req;
    l2_req_t    mem_req;
    l2_rsp_t    ic_rsp;
    l2_rsp_t    dc_rsp;
    l2_rsp_t    mem_rsp;
    addr_t      peek_addr;
    word_t      peek_rdata;
    logic       peek_miss;
    line_addr_t inv_line;
    logic       inv_req;

    icache i_icache (
        .clk(clk), .reset(reset),
        .fetch_rreq(fetch_rreq), .fetch_addr(fetch_addr),
        .fetch_rdata(fetch_rdata), .fetch_miss(fetch_miss),
        .l2_req(ic_req), .l2_rsp(ic_rsp),
        .peek_addr(peek_addr), .peek_rdata(peek_rdata), .peek_miss(peek_miss),
        .invalidate_line(inv_line), .invalidate_req(inv_req)
    );

    dcache i_dcache (
        .clk(clk), .reset(reset),
        .data_rreq(data_rreq), .data_wreq(data_wreq),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .data_rdata(data_rdata), .data_miss(data_miss),
        .l2_req(dc_req), .l2_rsp(dc_rsp),
        .peek_addr(peek_addr), .peek_rdata(peek_rdata), .peek_miss(peek_miss),
        .invalidate_line(inv_line), .invalidate_req(inv_req)
    );

    l2_arbiter i_l2_arbiter (
        .clk(clk), .reset(reset),
        .ic_req(ic_req), .ic_rsp(ic_rsp),
        .dc_req(dc_req), .dc_rsp(dc_rsp),
        .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    l2_memory #(
        .L2_LATENCY(L2_LATENCY),
        .MEM_WORDS(MEM_WORDS)
    ) i_l2_memory (
        .clk(clk), .reset(reset),
        .req(mem_req), .rsp(mem_rsp)
    );

endmodule

// File: tb_mem_subsystem.sv
module tb_mem_subsystem;
    timeunit 1ns;
    timeprecision 100ps;

    import cache_cfg_pkg::*;

    localparam int L2_LATENCY = 4;
    localparam int MEM_WORDS = 1024;
    localparam int ROUNDS = 8;
    localparam int DROP_ROUNDS = 4;
    localparam int PAIR_ROUNDS = 4;
    localparam int TEST_COUNT = ROUNDS * 7 + ROUNDS / 2 + DROP_ROUNDS * 4 + PAIR_ROUNDS * 4;
    localparam int OP_LIMIT = L2_LATENCY + 40;

    logic        clk;
    logic        reset;
    logic        fetch_rreq;
    addr_t       fetch_addr;
    word_t       fetch_rdata;
    logic        fetch_miss;
    logic        data_rreq;
    logic        data_wreq;
    addr_t       data_addr;
    word_t       data_wdata;
    word_t       data_rdata;
    logic        data_miss;

    word_t       shadow [MEM_WORDS];
    word_t       fetch_exp;
    word_t       data_exp;
    logic [31:0] lfsr;
    string       test_name;
    logic        fetch_first;
    logic        data_first;
    logic        want_fetch_hit;
    logic        want_fetch_miss;
    logic        want_data_miss;
    logic        req_seen;

    mem_subsystem #(
        .L2_LATENCY(L2_LATENCY),
        .MEM_WORDS(MEM_WORDS)
    ) i_mem_subsystem (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (3 + TEST_COUNT * OP_LIMIT) @(posedge clk);
        stop_with_error("watchdog timed out before the tests finished");
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    a_fetch_data: assert property (@(posedge clk) disable iff (reset)
        (fetch_rreq && !fetch_miss) |-> fetch_rdata == fetch_exp)
        else stop_with_error($sformatf("mismatch %s expected %h actual %h",
                                       test_name, fetch_exp, $sampled(fetch_rdata)));

    a_load_data: assert property (@(posedge clk) disable iff (reset)
        (data_rreq && !data_miss) |-> data_rdata == data_exp)
        else stop_with_error($sformatf("mismatch %s expected %h actual %h",
                                       test_name, data_exp, $sampled(data_rdata)));

    a_fetch_hit: assert property (@(posedge clk) disable iff (reset)
        (fetch_rreq && fetch_first && want_fetch_hit) |-> !fetch_miss)
        else stop_with_error({test_name, ": fetch missed on a line that was just filled"});

    a_fetch_miss: assert property (@(posedge clk) disable iff (reset)
        (fetch_rreq && fetch_first && want_fetch_miss) |-> fetch_miss)
        else stop_with_error({test_name, ": fetch hit a line that should be absent"});

    a_load_miss: assert property (@(posedge clk) disable iff (reset)
        (data_rreq && data_first && want_data_miss) |-> data_miss)
        else stop_with_error({test_name, ": load hit a line that should be absent"});

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
        !req_seen |-> (!fetch_miss && !data_miss))
        else stop_with_error("a miss was raised before any request was made");

    // Fibonacci LFSR with taps 32 22 2 1.
    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic take_nonzero(input int n, output logic [31:0] value);
        take_bits(n, value);
        if (value == '0) begin
            value = 32'd1;
        end
    endtask

    function automatic addr_t line_word(input logic [2:0] tag, input set_t set,
                                        input word_sel_t word);
        return {20'b0, tag, set, word, 2'b00};
    endfunction

    function automatic word_t shadow_at(input addr_t a);
        return shadow[a[11:2]];
    endfunction

    task automatic drive_fetch(input addr_t a);
        fetch_addr = a;
        fetch_exp = shadow_at(a);
        fetch_rreq = 1'b1;
        fetch_first = 1'b1;
        req_seen = 1'b1;
    endtask

    task automatic drive_load(input addr_t a);
        data_addr = a;
        data_exp = shadow_at(a);
        data_rreq = 1'b1;
        data_first = 1'b1;
        req_seen = 1'b1;
    endtask

    // Holds each request one cycle past its miss falling and then drops it.
    task automatic run_ops(input logic do_fetch, input logic do_data);
        int cycles;
        int f_stage;
        int d_stage;
        f_stage = do_fetch ? 0 : 2;
        d_stage = do_data ? 0 : 2;
        cycles = 0;
        while ((f_stage != 2 || d_stage != 2) && cycles < OP_LIMIT) begin
            @(negedge clk);
            cycles++;
            fetch_first = 1'b0;
            data_first = 1'b0;
            if (f_stage == 1) begin
                fetch_rreq = 1'b0;
                f_stage = 2;
            end else if (f_stage == 0 && !fetch_miss) begin
                f_stage = 1;
            end
            if (d_stage == 1) begin
                data_rreq = 1'b0;
                data_wreq = 1'b0;
                d_stage = 2;
            end else if (d_stage == 0 && !data_miss) begin
                d_stage = 1;
            end
        end
        if (f_stage != 2 || d_stage != 2) begin
            stop_with_error({test_name, ": request did not complete in time"});
        end
    endtask

    task automatic do_fetch(input string name, input addr_t a,
                            input logic want_hit, input logic want_miss);
        test_name = name;
        want_fetch_hit = want_hit;
        want_fetch_miss = want_miss;
        @(negedge clk);
        drive_fetch(a);
        run_ops(1'b1, 1'b0);
        want_fetch_hit = 1'b0;
        want_fetch_miss = 1'b0;
    endtask

    task automatic do_load(input string name, input addr_t a);
        test_name = name;
        @(negedge clk);
        drive_load(a);
        run_ops(1'b0, 1'b1);
    endtask

    task automatic do_store(input string name, input addr_t a, input word_t d);
        test_name = name;
        @(negedge clk);
        data_addr = a;
        data_wdata = d;
        data_wreq = 1'b1;
        data_first = 1'b1;
        req_seen = 1'b1;
        shadow[a[11:2]] = d;
        run_ops(1'b0, 1'b1);
    endtask

    task automatic do_pair(input string name, input addr_t fa, input addr_t la);
        test_name = name;
        want_fetch_miss = 1'b1;
        want_data_miss = 1'b1;
        @(negedge clk);
        drive_fetch(fa);
        drive_load(la);
        run_ops(1'b1, 1'b1);
        want_fetch_miss = 1'b0;
        want_data_miss = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] flip;
        logic [2:0]  tag;
        logic [2:0]  tag2;
        set_t        set;
        set_t        set2;
        word_sel_t   word;
        word_sel_t   word2;
        word_t       d;

        lfsr = 32'h8739_d985;
        reset = 1'b1;
        fetch_rreq = 1'b0;
        fetch_addr = '0;
        data_rreq = 1'b0;
        data_wreq = 1'b0;
        data_addr = '0;
        data_wdata = '0;
        fetch_exp = '0;
        data_exp = '0;
        test_name = "reset";
        fetch_first = 1'b0;
        data_first = 1'b0;
        want_fetch_hit = 1'b0;
        want_fetch_miss = 1'b0;
        want_data_miss = 1'b0;
        req_seen = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = word_t'(i * 4) ^ 32'hA5A5_0000;
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (4) @(negedge clk);

        for (int n = 0; n < ROUNDS; n++) begin
            take_bits(10, r);
            {tag, set, word} = r[9:0];
            take_nonzero(3, flip);
            word2 = word ^ flip[2:0];
            do_fetch("fetch_fill", line_word(tag, set, word), 1'b0, 1'b0);
            do_fetch("fetch_second_word", line_word(tag, set, word2), 1'b1, 1'b0);
        end

        for (int n = 0; n < ROUNDS; n++) begin
            take_bits(10, r);
            {tag, set, word} = r[9:0];
            take_nonzero(3, flip);
            word2 = word ^ flip[2:0];
            do_load("load_fill", line_word(tag, set, word));
            do_load("load_second_word", line_word(tag, set, word2));
        end

        // Even rounds preload the line so the fetch goes through the peek.
        for (int n = 0; n < ROUNDS; n++) begin
            take_bits(10, r);
            {tag, set, word} = r[9:0];
            take_bits(32, d);
            if (n % 2 == 0) begin
                do_load("load_before_store", line_word(tag, set, word));
            end
            do_store("store", line_word(tag, set, word), d);
            do_fetch("fetch_after_store", line_word(tag, set, word), 1'b0, 1'b0);
            do_load("load_after_store", line_word(tag, set, word));
        end

        for (int n = 0; n < DROP_ROUNDS; n++) begin
            take_bits(10, r);
            {tag, set, word} = r[9:0];
            take_nonzero(3, flip);
            tag2 = tag ^ flip[2:0];
            take_bits(3, r);
            word2 = r[2:0];
            take_bits(32, d);
            do_load("evict_dcache_line", line_word(tag2, set, word));
            do_fetch("fill_icache_line", line_word(tag, set, word), 1'b0, 1'b0);
            do_store("store_icache_line", line_word(tag, set, word2), d);
            do_fetch("fetch_dropped_line", line_word(tag, set, word2), 1'b0, 1'b1);
        end

        // Both requests miss, so one of them waits in the arbiter.
        for (int n = 0; n < PAIR_ROUNDS; n++) begin
            take_bits(10, r);
            {tag, set, word} = r[9:0];
            take_nonzero(4, flip);
            set2 = set ^ flip[3:0];
            take_bits(6, r);
            tag2 = r[5:3];
            word2 = r[2:0];
            do_load("evict_fetch_line", line_word(tag ^ 3'd2, set, word));
            do_fetch("refill_other_tag", line_word(tag ^ 3'd1, set, word), 1'b0, 1'b0);
            do_load("evict_load_line", line_word(tag2 ^ 3'd1, set2, word2));
            do_pair("fetch_load_pair", line_word(tag, set, word), line_word(tag2, set2, word2));
        end

        repeat (4) @(negedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: filelist.f
cache_cfg_pkg.sv
l2_bus_pkg.sv
icache.sv
dcache.sv
l2_arbiter.sv
l2_memory.sv
mem_subsystem.sv
tb_mem_subsystem.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert --timescale 1ns/100ps
TOP       = tb_mem_subsystem
FILELIST  = filelist.f
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -o $(TOP)
	-./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
